//--- rtl/muldiv_pkg.sv
`default_nettype none

package muldiv_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes and timing
    ////////////////////////////////////////////////////////////////////////////

    // Operand and HI/LO word width
    localparam int data_w = 32;

    // Accepted multiply to HI/LO writeback, in cycles
    localparam int mul_latency = 2;

    // One quotient bit per iteration
    localparam int div_steps = 32;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////////////////////

    // Encoding kept from the CPU decode stage
    typedef enum logic [3:0] {
        none  = 4'd0,
        div   = 4'd1,
        divu  = 4'd2,
        mfhi  = 4'd3,
        mflo  = 4'd4,
        mthi  = 4'd5,
        mtlo  = 4'd6,
        mul   = 4'd7,
        mult  = 4'd8,
        multu = 4'd9
    } md_op_t;

    ////////////////////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////////////////////

    // One request from the pipeline
    typedef struct packed {
        md_op_t             op;
        logic [data_w-1:0]  rs;
        logic [data_w-1:0]  rt;
    } md_req_t;

    // Writeback into HI/LO
    // Each half has its own enable
    typedef struct packed {
        logic [data_w-1:0]  hi;
        logic [data_w-1:0]  lo;
        logic               hi_en;
        logic               lo_en;
    } md_wb_t;

    // Result word back to the pipeline
    typedef struct packed {
        logic [data_w-1:0]  data;
    } md_res_t;

endpackage

`default_nettype wire

//--- rtl/md_hilo.sv
`timescale 1ns/1ps
`default_nettype none

module md_hilo (
    input  wire                 clk,
    input  wire                 rst,
    // Move operations from dispatch
    input  logic                mv_valid,
    input  muldiv_pkg::md_req_t mv_req,
    // Arithmetic writebacks
    input  logic                mul_wb_valid,
    input  muldiv_pkg::md_wb_t  mul_wb,
    input  logic                div_wb_valid,
    input  muldiv_pkg::md_wb_t  div_wb,
    // mfhi/mflo answer
    output muldiv_pkg::md_res_t mv_res,
    output logic                mv_res_valid
);

    logic [muldiv_pkg::data_w-1:0] hi;
    logic [muldiv_pkg::data_w-1:0] lo;

    // Merged writeback, only one source active at a time
    logic                          wb_valid;
    muldiv_pkg::md_wb_t            wb;

    assign wb_valid = mul_wb_valid || div_wb_valid;
    assign wb       = mul_wb_valid ? mul_wb : div_wb;

    ////////////////////////////////////////////////////////////////////////////
    // HI/LO registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end else begin
            // Arithmetic results
            if (wb_valid && wb.hi_en)
                hi <= wb.hi;
            if (wb_valid && wb.lo_en)
                lo <= wb.lo;
            // mthi/mtlo take rs
            if (mv_valid && mv_req.op == muldiv_pkg::mthi)
                hi <= mv_req.rs;
            if (mv_valid && mv_req.op == muldiv_pkg::mtlo)
                lo <= mv_req.rs;
        end
    end

    // Reads see HI/LO before this edge
    always_ff @(posedge clk) begin
        if (rst)
            mv_res_valid <= 1'b0;
        else
            mv_res_valid <= mv_valid &&
                (mv_req.op == muldiv_pkg::mfhi || mv_req.op == muldiv_pkg::mflo);
        mv_res.data <= (mv_req.op == muldiv_pkg::mfhi) ? hi : lo;
    end

    // Busy tracking in the top keeps the two units apart
    a_wb_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mul_wb_valid && div_wb_valid))
        else $error("md_hilo: multiply and divide writebacks collided");

endmodule

`default_nettype wire

//--- rtl/md_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module md_multiplier (
    input  wire                            clk,
    input  wire                            rst,
    input  logic                           start,
    input  muldiv_pkg::md_req_t            req,
    output logic                           wb_valid,
    output muldiv_pkg::md_wb_t             wb,
    output logic                           lo_valid,
    output logic [muldiv_pkg::data_w-1:0]  lo
);

    // Stage 1 operands, one extra bit carries the sign or a zero
    logic                                  s1_valid;
    logic                                  s1_mul;
    logic signed [muldiv_pkg::data_w:0]    s1_a;
    logic signed [muldiv_pkg::data_w:0]    s1_b;
    logic signed [2*muldiv_pkg::data_w+1:0] prod;

    // Stage 2 product
    logic                                  s2_valid;
    logic                                  s2_mul;
    logic [2*muldiv_pkg::data_w-1:0]       s2_prod;
    logic                                  ext;

    // multu is the only unsigned one
    assign ext  = (req.op != muldiv_pkg::multu);
    assign prod = s1_a * s1_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            lo_valid <= 1'b0;
        end else begin
            s1_valid <= start;
            s2_valid <= s1_valid;
            lo_valid <= s2_valid && s2_mul;
        end
        // Stage 1
        s1_mul  <= (req.op == muldiv_pkg::mul);
        s1_a    <= {ext & req.rs[muldiv_pkg::data_w-1], req.rs};
        s1_b    <= {ext & req.rt[muldiv_pkg::data_w-1], req.rt};
        // Stage 2, low 64 bits are exact for both signs
        s2_mul  <= s1_mul;
        s2_prod <= prod[2*muldiv_pkg::data_w-1:0];
        // mul result one edge after the writeback slot
        lo      <= s2_prod[muldiv_pkg::data_w-1:0];
    end

    // mul leaves HI/LO alone but still signals completion
    assign wb_valid = s2_valid;
    assign wb.hi    = s2_prod[2*muldiv_pkg::data_w-1:muldiv_pkg::data_w];
    assign wb.lo    = s2_prod[muldiv_pkg::data_w-1:0];
    assign wb.hi_en = !s2_mul;
    assign wb.lo_en = !s2_mul;

endmodule

`default_nettype wire

//--- rtl/md_divider.sv
`timescale 1ns/1ps
`default_nettype none

module md_divider (
    input  wire                 clk,
    input  wire                 rst,
    input  logic                start,
    input  muldiv_pkg::md_req_t req,
    output logic                wb_valid,
    output muldiv_pkg::md_wb_t  wb
);

    // Control
    logic                                         run_q;
    logic                                         done_q;
    logic [$clog2(muldiv_pkg::div_steps)-1:0]     cnt;

    // Datapath, quo_q holds the dividend bits until they shift out
    logic [muldiv_pkg::data_w-1:0]                rem_q;
    logic [muldiv_pkg::data_w-1:0]                quo_q;
    logic [muldiv_pkg::data_w-1:0]                dvs_q;
    logic [muldiv_pkg::data_w-1:0]                rs_q;
    logic                                         quo_neg;
    logic                                         rem_neg;
    logic                                         zero_q;

    // Operand magnitudes at start
    logic                                         sgn;
    logic [muldiv_pkg::data_w-1:0]                rs_mag;
    logic [muldiv_pkg::data_w-1:0]                rt_mag;

    // One restoring step
    logic [muldiv_pkg::data_w:0]                  r_sh;
    logic [muldiv_pkg::data_w:0]                  diff;

    assign sgn    = (req.op == muldiv_pkg::div);
    assign rs_mag = (sgn && req.rs[muldiv_pkg::data_w-1]) ? -req.rs : req.rs;
    assign rt_mag = (sgn && req.rt[muldiv_pkg::data_w-1]) ? -req.rt : req.rt;

    // Bring down next dividend bit and try the subtract
    assign r_sh = {rem_q, quo_q[muldiv_pkg::data_w-1]};
    assign diff = r_sh - {1'b0, dvs_q};

    ////////////////////////////////////////////////////////////////////////////
    // Step control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            run_q  <= 1'b0;
            done_q <= 1'b0;
            cnt    <= '0;
        end else begin
            done_q <= 1'b0;
            if (start) begin
                run_q <= 1'b1;
                cnt   <= '0;
            end else if (run_q) begin
                cnt <= cnt + 1'b1;
                // Last iteration, sign fix follows
                if (cnt == muldiv_pkg::div_steps - 1) begin
                    run_q  <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (start) begin
            rem_q   <= '0;
            quo_q   <= rs_mag;
            dvs_q   <= rt_mag;
            rs_q    <= req.rs;
            quo_neg <= sgn && (req.rs[muldiv_pkg::data_w-1] ^ req.rt[muldiv_pkg::data_w-1]);
            rem_neg <= sgn && req.rs[muldiv_pkg::data_w-1];
            zero_q  <= (req.rt == '0);
        end else if (run_q) begin
            // Keep the trial only when it stays non-negative
            if (!diff[muldiv_pkg::data_w]) begin
                rem_q <= diff[muldiv_pkg::data_w-1:0];
                quo_q <= {quo_q[muldiv_pkg::data_w-2:0], 1'b1};
            end else begin
                rem_q <= r_sh[muldiv_pkg::data_w-1:0];
                quo_q <= {quo_q[muldiv_pkg::data_w-2:0], 1'b0};
            end
        end
    end

    // Signs applied on the way out, zero divisor overrides
    assign wb_valid = done_q;
    assign wb.hi    = zero_q ? rs_q : (rem_neg ? -rem_q : rem_q);
    assign wb.lo    = zero_q ? '1 : (quo_neg ? -quo_q : quo_q);
    assign wb.hi_en = 1'b1;
    assign wb.lo_en = 1'b1;

    // One divide at a time
    a_no_restart: assert property (@(posedge clk) disable iff (rst)
        start |-> !(run_q || done_q))
        else $error("md_divider: start while a divide is in progress");

    // Fixed latency, load plus the steps plus the writeback slot
    a_latency: assert property (@(posedge clk) disable iff (rst)
        start |=> !wb_valid [*muldiv_pkg::div_steps] ##1 wb_valid)
        else $error("md_divider: writeback not 33 cycles after start");

endmodule

`default_nettype wire

//--- rtl/muldiv_top.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_top (
    input  wire                 clk,
    input  wire                 rst,
    input  logic                req_valid,
    input  muldiv_pkg::md_req_t req,
    output logic                res_valid,
    output muldiv_pkg::md_res_t res,
    output logic                busy
);

    logic                          accept;
    logic                          mul_start;
    logic                          div_start;
    logic                          mv_valid;

    logic                          mul_wb_valid;
    muldiv_pkg::md_wb_t            mul_wb;
    logic                          mul_res_valid;
    logic [muldiv_pkg::data_w-1:0] mul_lo;
    logic                          div_wb_valid;
    muldiv_pkg::md_wb_t            div_wb;
    muldiv_pkg::md_res_t           mv_res;
    logic                          mv_res_valid;

    ////////////////////////////////////////////////////////////////////////////
    // Dispatch
    ////////////////////////////////////////////////////////////////////////////

    // Requests during busy are dropped
    assign accept = req_valid && !busy && (req.op != muldiv_pkg::none);

    always_comb begin
        mul_start = 1'b0;
        div_start = 1'b0;
        mv_valid  = 1'b0;
        case (req.op)
            muldiv_pkg::mul, muldiv_pkg::mult, muldiv_pkg::multu:
                mul_start = accept;
            muldiv_pkg::div, muldiv_pkg::divu:
                div_start = accept;
            muldiv_pkg::mfhi, muldiv_pkg::mflo, muldiv_pkg::mthi, muldiv_pkg::mtlo:
                mv_valid = accept;
            default: ;
        endcase
    end

    // Set on multiply or divide, dropped at the writeback edge
    // mul also ends with a writeback strobe, enables off
    always_ff @(posedge clk) begin
        if (rst)
            busy <= 1'b0;
        else if (mul_start || div_start)
            busy <= 1'b1;
        else if (mul_wb_valid || div_wb_valid)
            busy <= 1'b0;
    end

    md_hilo u_hilo (
        .clk(clk), .rst(rst),
        .mv_valid(mv_valid), .mv_req(req),
        .mul_wb_valid(mul_wb_valid), .mul_wb(mul_wb),
        .div_wb_valid(div_wb_valid), .div_wb(div_wb),
        .mv_res(mv_res), .mv_res_valid(mv_res_valid)
    );

    md_multiplier u_mul (
        .clk(clk), .rst(rst), .start(mul_start), .req(req),
        .wb_valid(mul_wb_valid), .wb(mul_wb),
        .lo_valid(mul_res_valid), .lo(mul_lo)
    );

    md_divider u_div (
        .clk(clk), .rst(rst), .start(div_start), .req(req),
        .wb_valid(div_wb_valid), .wb(div_wb)
    );

    // Result mux
    assign res_valid = mv_res_valid || mul_res_valid;
    assign res.data  = mul_res_valid ? mul_lo : mv_res.data;

    // Busy keeps a move read away from a mul result
    a_res_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mv_res_valid && mul_res_valid))
        else $error("muldiv_top: move and mul results overlap");

    // Multiply writes back while busy still holds
    a_mul_latency: assert property (@(posedge clk) disable iff (rst)
        mul_start |-> ##(muldiv_pkg::mul_latency) (mul_wb_valid && busy))
        else $error("muldiv_top: multiply writeback off schedule");

endmodule

`default_nettype wire

//--- tests/muldiv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_tb;

    // Enough for a few hundred divides with reads
    localparam int max_cycles = 20000;

    typedef struct packed {
        logic [muldiv_pkg::data_w-1:0] hi;
        logic [muldiv_pkg::data_w-1:0] lo;
        logic [muldiv_pkg::data_w-1:0] data;
    } ref_t;

    logic                          clk;
    logic                          rst;
    logic                          req_valid;
    muldiv_pkg::md_req_t           req;
    logic                          res_valid;
    muldiv_pkg::md_res_t           res;
    logic                          busy;

    // HI/LO as the model sees them
    logic [muldiv_pkg::data_w-1:0] model_hi;
    logic [muldiv_pkg::data_w-1:0] model_lo;
    logic [muldiv_pkg::data_w-1:0] exp_q[$];
    int                            err_cnt;
    int                            chk_cnt;
    int                            cyc;
    int                            test_no;

    muldiv_top uut (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req(req),
        .res_valid(res_valid), .res(res), .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic ref_t md_ref(input muldiv_pkg::md_op_t op,
                                    input logic [31:0] rs, input logic [31:0] rt,
                                    input logic [31:0] hi, input logic [31:0] lo);
        ref_t               r;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] sp;
        logic        [63:0] up;
        logic signed [31:0] dn;
        logic signed [31:0] dd;
        r  = '{hi: hi, lo: lo, data: '0};
        sa = {{32{rs[31]}}, rs};
        sb = {{32{rt[31]}}, rt};
        sp = sa * sb;
        up = {32'b0, rs} * {32'b0, rt};
        dn = rs;
        dd = rt;
        case (op)
            muldiv_pkg::mult:  {r.hi, r.lo} = sp;
            muldiv_pkg::multu: {r.hi, r.lo} = up;
            muldiv_pkg::mul:   r.data = sp[31:0];
            muldiv_pkg::mfhi:  r.data = hi;
            muldiv_pkg::mflo:  r.data = lo;
            muldiv_pkg::mthi:  r.hi = rs;
            muldiv_pkg::mtlo:  r.lo = rs;
            muldiv_pkg::div, muldiv_pkg::divu: begin
                // Zero divisor, then signed overflow, then plain division
                if (rt == '0) begin
                    r.lo = '1;
                    r.hi = rs;
                end else if (op == muldiv_pkg::div && rs == 32'h80000000 && rt == '1) begin
                    r.lo = 32'h80000000;
                    r.hi = '0;
                end else if (op == muldiv_pkg::div) begin
                    r.lo = dn / dd;
                    r.hi = dn % dd;
                end else begin
                    r.lo = rs / rt;
                    r.hi = rs % rt;
                end
            end
            default: ;
        endcase
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // Returns right after the edge that samples the request
    task automatic drive_req(input muldiv_pkg::md_op_t op, input logic [31:0] rs,
                             input logic [31:0] rt);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= '{op: op, rs: rs, rt: rt};
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic apply_model(input muldiv_pkg::md_op_t op, input logic [31:0] rs,
                               input logic [31:0] rt);
        ref_t r;
        r        = md_ref(op, rs, rt, model_hi, model_lo);
        model_hi = r.hi;
        model_lo = r.lo;
        if (op == muldiv_pkg::mfhi || op == muldiv_pkg::mflo || op == muldiv_pkg::mul)
            exp_q.push_back(r.data);
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (busy)
            @(negedge clk);
    endtask

    task automatic run_op(input muldiv_pkg::md_op_t op, input logic [31:0] rs,
                          input logic [31:0] rt);
        drive_req(op, rs, rt);
        apply_model(op, rs, rt);
        @(negedge clk);
        // Move reads answer one cycle after acceptance
        if (op == muldiv_pkg::mfhi || op == muldiv_pkg::mflo)
            check_value("res_valid", res_valid, 1);
        while (busy)
            @(negedge clk);
    endtask

    task automatic read_hilo();
        run_op(muldiv_pkg::mfhi, '0, '0);
        run_op(muldiv_pkg::mflo, '0, '0);
    endtask

    task automatic report_test(input string name);
        test_no++;
        $display("test %0d %s finished, %0d errors so far", test_no, name, err_cnt);
    endtask

    // Every result strobe consumes one expected value
    always @(negedge clk) begin
        if (!rst && res_valid) begin
            if (exp_q.size() == 0) begin
                $display("DUT gave a result that no request asked for");
                err_cnt++;
            end else begin
                check_value("res.data", res.data, exp_q.pop_front());
            end
        end
    end

    initial begin
        cyc = 0;
        while (cyc < max_cycles) begin
            @(posedge clk);
            cyc++;
        end
        $display("run timed out after %0d cycles before the tests completed", cyc);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] corner [4];
        logic [31:0] a;
        logic [31:0] b;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        model_hi  = '0;
        model_lo  = '0;
        err_cnt   = 0;
        chk_cnt   = 0;
        test_no   = 0;
        corner    = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000};
        void'($urandom(32'hec80b1fe));
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Quiet outputs and zeroed HI/LO
        @(negedge clk);
        check_value("busy", busy, 0);
        check_value("res_valid", res_valid, 0);
        read_hilo();
        report_test("reset state");

        for (int i = 0; i < 4; i++) begin
            run_op(muldiv_pkg::mthi, $urandom, '0);
            run_op(muldiv_pkg::mtlo, $urandom, '0);
            read_hilo();
        end
        report_test("moves");

        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                run_op(muldiv_pkg::mult, corner[i], corner[j]);
                read_hilo();
                run_op(muldiv_pkg::multu, corner[i], corner[j]);
                read_hilo();
            end
        end
        for (int i = 0; i < 20; i++) begin
            if (i % 2)
                run_op(muldiv_pkg::multu, $urandom, $urandom);
            else
                run_op(muldiv_pkg::mult, $urandom, $urandom);
            read_hilo();
        end
        report_test("mult and multu");

        // HI/LO must survive mul
        for (int i = 0; i < 12; i++) begin
            a = (i < 4) ? corner[i] : $urandom;
            run_op(muldiv_pkg::mul, a, $urandom);
            read_hilo();
        end
        report_test("mul");

        run_op(muldiv_pkg::div, 32'h80000000, 32'hffffffff);
        read_hilo();
        run_op(muldiv_pkg::div, 32'h12345678, '0);
        read_hilo();
        run_op(muldiv_pkg::divu, 32'h87654321, '0);
        read_hilo();
        for (int i = 0; i < 4; i++) begin
            a = (i % 2) ? -32'sd7 : 32'sd7;
            b = (i / 2) ? -32'sd2 : 32'sd2;
            run_op(muldiv_pkg::div, a, b);
            read_hilo();
        end
        for (int i = 0; i < 60; i++) begin
            a = $urandom;
            b = $urandom >> ($urandom % 32);
            if ($urandom % 2)
                b = -b;
            if (i % 2)
                run_op(muldiv_pkg::divu, a, b);
            else
                run_op(muldiv_pkg::div, a, b);
            read_hilo();
        end
        report_test("div and divu");

        // Requests under busy leave no trace
        drive_req(muldiv_pkg::div, 32'hdeadbeef, 32'h00001234);
        apply_model(muldiv_pkg::div, 32'hdeadbeef, 32'h00001234);
        drive_req(muldiv_pkg::mult, 32'h11111111, 32'h22222222);
        drive_req(muldiv_pkg::mfhi, '0, '0);
        drive_req(muldiv_pkg::divu, 32'h5, 32'h3);
        // The divu went in at edge 6, divide writeback is at edge div_steps + 1
        // A move sampled on that edge would overwrite LO if it got through
        repeat (muldiv_pkg::div_steps - 7) @(posedge clk);
        drive_req(muldiv_pkg::mtlo, 32'h0badf00d, '0);
        wait_idle();
        read_hilo();
        report_test("drop while busy");

        repeat (3) @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d expected results never appeared on res", exp_q.size());
            err_cnt++;
        end
        $display("%0d tests, %0d checks, %0d errors", test_no, chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- muldiv_top.f
rtl/muldiv_pkg.sv
rtl/md_hilo.sv
rtl/md_multiplier.sv
rtl/md_divider.sv
rtl/muldiv_top.sv
tests/muldiv_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the muldiv testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module muldiv_tb \
    -f muldiv_top.f -o muldiv_sim || exit 1

out=$(./obj_dir/muldiv_sim)
echo "$out"

echo "$out" | grep -qx "TEST OK" && exit 0 || exit 1
